// ==== hdl/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// address and instruction width
`define FETCH_XLEN          32

// instruction order counter
`define FETCH_ORDER_W       64

// one line holds eight instruction words
`define FETCH_LINE_W        256

// memory side burst beats
`define FETCH_BEAT_W        64
`define FETCH_BEATS         4

`define FETCH_QUEUE_DEPTH   16

`define FETCH_RESET_PC      32'haaaaa000

`endif

// ==== hdl/fetch_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   redirect_i,
    input  logic [`FETCH_XLEN-1:0] redirect_pc_i,

    line_fill_if.requester         fill,
    fetch_queue_if.producer        enq
);

    localparam int OFFSET_W = $clog2(`FETCH_LINE_W / 8);
    localparam int TAG_W    = `FETCH_XLEN - OFFSET_W;
    localparam int WORD_W   = OFFSET_W - 2;

    fetch_state_e              state;
    logic [`FETCH_XLEN-1:0]    pc_q;
    logic [`FETCH_ORDER_W-1:0] order_q;

    // single line buffer
    cache_line_t               buf_line;
    logic [TAG_W-1:0]          buf_tag;
    logic                      buf_valid;

    logic [WORD_W-1:0]         word_sel;
    logic                      hit;
    logic                      enq_fire;
    logic                      fill_done;

    assign word_sel = pc_q[OFFSET_W-1:2];
    assign hit      = buf_valid && (buf_tag == pc_q[`FETCH_XLEN-1:OFFSET_W]);

    // nothing is enqueued in a redirect cycle, the queue is flushed anyway
    assign enq_fire = (state == fetch_lookup) && hit && !enq.full && !redirect_i;

    assign enq.enq_valid = enq_fire;
    assign enq.enq_entry = '{
        order: order_q,
        pc:    pc_q,
        inst:  buf_line[word_sel*`FETCH_XLEN +: `FETCH_XLEN]
    };

    assign fill.fill_req  = (state == fetch_request) && !fill.fill_busy && !redirect_i;
    assign fill.fill_addr = {pc_q[`FETCH_XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // line arrives for the current pc
    assign fill_done = (state == fetch_wait) && fill.fill_resp && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= fetch_lookup;
            pc_q      <= `FETCH_RESET_PC;
            order_q   <= '0;
            buf_valid <= 1'b0;
        end else if (redirect_i) begin
            pc_q      <= redirect_pc_i;
            buf_valid <= 1'b0;
            case (state)
                // outstanding fill must still be swallowed
                fetch_wait, fetch_drain: begin
                    state <= fill.fill_resp ? fetch_lookup : fetch_drain;
                end
                default: state <= fetch_lookup;
            endcase
        end else begin
            case (state)
                fetch_lookup: begin
                    if (enq_fire) begin
                        pc_q    <= pc_q + 32'd4;
                        order_q <= order_q + 1'b1;
                    end else if (!hit) begin
                        state <= fetch_request;
                    end
                end
                fetch_request: begin
                    if (fill.fill_req) begin
                        state <= fetch_wait;
                    end
                end
                fetch_wait: begin
                    if (fill.fill_resp) begin
                        buf_valid <= 1'b1;
                        state     <= fetch_lookup;
                    end
                end
                fetch_drain: begin
                    // stale line is dropped
                    if (fill.fill_resp) begin
                        state <= fetch_lookup;
                    end
                end
                default: state <= fetch_lookup;
            endcase
        end
    end

    // line data and tag
    always_ff @(posedge clk) begin
        if (fill_done) begin
            buf_line <= fill.fill_line;
            buf_tag  <= pc_q[`FETCH_XLEN-1:OFFSET_W];
        end
    end

endmodule

// ==== hdl/fetch_frontend.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_frontend
    import fetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // burst memory
    output logic [`FETCH_XLEN-1:0]    bmem_addr_o,
    output logic                      bmem_read_o,
    input  logic                      bmem_ready_i,
    input  logic [`FETCH_XLEN-1:0]    bmem_raddr_i,
    input  logic [`FETCH_BEAT_W-1:0]  bmem_rdata_i,
    input  logic                      bmem_rvalid_i,

    input  logic                      redirect_i,
    input  logic [`FETCH_XLEN-1:0]    redirect_pc_i,

    // instruction stream out
    output logic                      inst_valid_o,
    input  logic                      inst_ready_i,
    output logic [`FETCH_XLEN-1:0]    inst_o,
    output logic [`FETCH_XLEN-1:0]    inst_pc_o,
    output logic [`FETCH_ORDER_W-1:0] inst_order_o
);

    line_fill_if   fill_bus ();
    fetch_queue_if queue_bus ();

    fetch_entry_t  deq_entry;

    fetch_ctrl fetch_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fill          (fill_bus.requester),
        .enq           (queue_bus.producer)
    );

    line_fill_adapter line_fill_adapter_inst (
        .clk           (clk),
        .rst           (rst),
        .fill          (fill_bus.filler),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    // redirect also empties the queue
    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) fetch_queue_inst (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),
        .enq         (queue_bus.store),
        .deq_valid_o (inst_valid_o),
        .deq_ready_i (inst_ready_i),
        .deq_entry_o (deq_entry)
    );

    assign inst_o       = deq_entry.inst;
    assign inst_pc_o    = deq_entry.pc;
    assign inst_order_o = deq_entry.order;

endmodule

// ==== hdl/fetch_ifs.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

// line fill request and response between fetch control and the memory adapter
interface line_fill_if
    import fetch_pkg::*;
();
    logic                   fill_req;
    logic [`FETCH_XLEN-1:0] fill_addr;
    logic                   fill_busy;
    logic                   fill_resp;
    cache_line_t            fill_line;

    modport requester (
        output fill_req,
        output fill_addr,
        input  fill_busy,
        input  fill_resp,
        input  fill_line
    );

    modport filler (
        input  fill_req,
        input  fill_addr,
        output fill_busy,
        output fill_resp,
        output fill_line
    );
endinterface

// enqueue side of the instruction queue
interface fetch_queue_if
    import fetch_pkg::*;
();
    logic         enq_valid;
    fetch_entry_t enq_entry;
    logic         full;

    modport producer (
        output enq_valid,
        output enq_entry,
        input  full
    );

    modport store (
        input  enq_valid,
        input  enq_entry,
        output full
    );
endinterface

// ==== hdl/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    // one instruction queue entry, 128 bits
    typedef struct packed {
        logic [`FETCH_ORDER_W-1:0] order;
        logic [`FETCH_XLEN-1:0]    pc;
        logic [`FETCH_XLEN-1:0]    inst;
    } fetch_entry_t;

    // full memory line as returned by the fill adapter
    typedef logic [`FETCH_LINE_W-1:0] cache_line_t;

    // fetch controller
    typedef enum logic [1:0] {
        fetch_lookup,
        fetch_request,
        fetch_wait,
        // a fill is outstanding but its line is no longer wanted
        fetch_drain
    } fetch_state_e;

    // burst read adapter
    typedef enum logic [1:0] {
        fill_idle,
        fill_issue,
        fill_collect
    } fill_state_e;

endpackage

// ==== hdl/fetch_queue.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         flush_i,

    fetch_queue_if.store enq,

    output logic         deq_valid_o,
    input  logic         deq_ready_i,
    output fetch_entry_t deq_entry_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_entry_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             enq_fire;
    logic             deq_fire;

    assign enq.full    = (count == CNT_W'(DEPTH));
    assign deq_valid_o = (count != '0);
    // head is visible without a read strobe
    assign deq_entry_o = mem[rd_ptr];

    assign enq_fire = enq.enq_valid && !enq.full;
    assign deq_fire = deq_valid_o && deq_ready_i;

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({enq_fire, deq_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq.enq_entry;
        end
    end

endmodule

// ==== hdl/line_fill_adapter.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module line_fill_adapter
    import fetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    line_fill_if.filler              fill,

    output logic [`FETCH_XLEN-1:0]   bmem_addr_o,
    output logic                     bmem_read_o,
    input  logic                     bmem_ready_i,
    input  logic [`FETCH_XLEN-1:0]   bmem_raddr_i,
    input  logic [`FETCH_BEAT_W-1:0] bmem_rdata_i,
    input  logic                     bmem_rvalid_i
);

    localparam int BEAT_CNT_W = $clog2(`FETCH_BEATS);

    fill_state_e            state;
    logic [`FETCH_XLEN-1:0] req_addr;
    cache_line_t            line_q;
    logic [BEAT_CNT_W-1:0]  beat_cnt;
    logic                   resp_q;
    logic                   beat_fire;

    // read goes out in the cycle memory is ready
    assign bmem_addr_o = req_addr;
    assign bmem_read_o = (state == fill_issue) && bmem_ready_i;

    // only beats tagged with our request address count
    assign beat_fire = (state == fill_collect) && bmem_rvalid_i && (bmem_raddr_i == req_addr);

    assign fill.fill_busy = (state != fill_idle);
    assign fill.fill_resp = resp_q;
    assign fill.fill_line = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= fill_idle;
            beat_cnt <= '0;
            resp_q   <= 1'b0;
        end else begin
            resp_q <= 1'b0;
            case (state)
                fill_idle: begin
                    if (fill.fill_req) begin
                        state <= fill_issue;
                    end
                end
                fill_issue: begin
                    if (bmem_ready_i) begin
                        state    <= fill_collect;
                        beat_cnt <= '0;
                    end
                end
                fill_collect: begin
                    if (beat_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // last beat, response follows one cycle later
                        if (beat_cnt == BEAT_CNT_W'(`FETCH_BEATS - 1)) begin
                            state  <= fill_idle;
                            resp_q <= 1'b1;
                        end
                    end
                end
                default: state <= fill_idle;
            endcase
        end
    end

    // request address and line assembly
    always_ff @(posedge clk) begin
        if ((state == fill_idle) && fill.fill_req) begin
            req_addr <= fill.fill_addr;
        end
        if (beat_fire) begin
            line_q[beat_cnt*`FETCH_BEAT_W +: `FETCH_BEAT_W] <= bmem_rdata_i;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fetch_frontend -f src.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation stopped with an error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0

// ==== src.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_ifs.sv
hdl/line_fill_adapter.sv
hdl/fetch_queue.sv
hdl/fetch_ctrl.sv
hdl/fetch_frontend.sv
tb/clk_gen.sv
tb/fetch_assert.sv
tb/tb_fetch_frontend.sv

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk_o
);

    // 10 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD) clk_o = ~clk_o;
        end
    end

endmodule

// ==== tb/fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert (
    input logic clk,
    input logic rst,
    input logic bmem_read_i,
    input logic bmem_ready_i,
    input logic redirect_i,
    input logic inst_valid_i
);

    // a burst read only leaves in a ready cycle
    read_needs_ready: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> bmem_ready_i)
        else $error("burst read issued while memory not ready");

    // redirect flushes the queue
    flush_hides_output: assert property (@(posedge clk) disable iff (rst)
        redirect_i |=> !inst_valid_i)
        else $error("instruction valid in the cycle after a redirect");

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> (!bmem_read_i && !inst_valid_i))
        else $error("read or valid strobe active right after reset");

endmodule

bind fetch_frontend fetch_assert fetch_assert_inst (
    .clk          (clk),
    .rst          (rst),
    .bmem_read_i  (bmem_read_o),
    .bmem_ready_i (bmem_ready_i),
    .redirect_i   (redirect_i),
    .inst_valid_i (inst_valid_o)
);

// ==== tb/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`include "fetch_config.svh"

module tb_fetch_frontend;

    localparam int          SEED      = 27;
    localparam int          TIMEOUT   = 2000;
    localparam logic [31:0] WORD_MASK = 32'h5a5a0000;

    logic                      clk;
    logic                      rst;
    logic [`FETCH_XLEN-1:0]    bmem_addr_o;
    logic                      bmem_read_o;
    logic                      bmem_ready_i;
    logic [`FETCH_XLEN-1:0]    bmem_raddr_i;
    logic [`FETCH_BEAT_W-1:0]  bmem_rdata_i;
    logic                      bmem_rvalid_i;
    logic                      redirect_i;
    logic [`FETCH_XLEN-1:0]    redirect_pc_i;
    logic                      inst_valid_o;
    logic                      inst_ready_i;
    logic [`FETCH_XLEN-1:0]    inst_o;
    logic [`FETCH_XLEN-1:0]    inst_pc_o;
    logic [`FETCH_ORDER_W-1:0] inst_order_o;

    // reference model
    logic [31:0] exp_pc;
    logic [63:0] exp_order;
    logic [31:0] next_line;
    logic [31:0] stale_line;
    logic        stale_ok;
    // memory model, one burst at a time
    logic        mem_busy;
    logic [31:0] mem_addr;
    logic [31:0] beat_off;
    // stimulus control
    int          ready_pct;
    logic        want_redirect;
    logic        need_fill;
    logic [31:0] target_pc;
    logic        redirect_prev;
    int          delivered;
    int          value_errs;
    int          proto_errs;
    int          timeouts;
    logic        aborted;

    clk_gen clk_gen_inst (.clk_o(clk));

    fetch_frontend fetch_frontend_inst (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .inst_valid_o  (inst_valid_o),
        .inst_ready_i  (inst_ready_i),
        .inst_o        (inst_o),
        .inst_pc_o     (inst_pc_o),
        .inst_order_o  (inst_order_o)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ WORD_MASK;
    endfunction

    task automatic check_read();
        assert (bmem_ready_i) else begin
            $display("burst read issued while memory was not ready");
            proto_errs++;
        end
        assert (bmem_addr_o[4:0] == 5'd0) else begin
            $display("** Error: bmem_addr_o = %h, not line aligned", bmem_addr_o);
            value_errs++;
        end
        assert (bmem_addr_o == next_line || (stale_ok && bmem_addr_o == stale_line)) else begin
            $display("** Error: bmem_addr_o = %h, expected %h", bmem_addr_o, next_line);
            value_errs++;
        end
        if (bmem_addr_o == next_line) begin
            next_line = next_line + 32'd32;
        end
        stale_ok = 1'b0;
        mem_busy = 1'b1;
        mem_addr = bmem_addr_o;
        beat_off = 32'd0;
    endtask

    task automatic check_delivery();
        assert (inst_pc_o == exp_pc) else begin
            $display("** Error: inst_pc_o = %h, expected %h", inst_pc_o, exp_pc);
            value_errs++;
        end
        assert (inst_o == mem_word(exp_pc)) else begin
            $display("** Error: inst_o = %h, expected %h", inst_o, mem_word(exp_pc));
            value_errs++;
        end
        assert (inst_order_o == exp_order) else begin
            $display("** Error: inst_order_o = %h, expected %h", inst_order_o, exp_order);
            value_errs++;
        end
        exp_pc    = exp_pc + 32'd4;
        exp_order = exp_order + 64'd1;
        delivered++;
    endtask

    // drive on the falling edge, then look at what the rising edge will take
    task automatic step_cycle();
        logic beat_out;
        @(negedge clk);
        beat_out      = 1'b0;
        bmem_ready_i  = !mem_busy && (($urandom % 100) < 70);
        bmem_rvalid_i = 1'b0;
        if (mem_busy && (($urandom % 100) < 60)) begin
            beat_out      = 1'b1;
            bmem_rvalid_i = 1'b1;
            bmem_raddr_i  = mem_addr;
            bmem_rdata_i  = {mem_word(mem_addr + beat_off + 32'd4), mem_word(mem_addr + beat_off)};
        end
        inst_ready_i = (($urandom % 100) < ready_pct);
        redirect_i   = 1'b0;
        // queue must be empty so no order number is flushed away
        if (want_redirect && !inst_valid_o && (!need_fill || mem_busy)) begin
            if ({target_pc[31:5], 5'd0} == next_line) begin
                target_pc = target_pc + 32'd64;
            end
            redirect_i    = 1'b1;
            redirect_pc_i = target_pc;
            want_redirect = 1'b0;
        end
        #1;
        if (redirect_prev) begin
            assert (!inst_valid_o) else begin
                $display("** Error: inst_valid_o = %h after redirect, expected 0", inst_valid_o);
                value_errs++;
            end
        end
        redirect_prev = redirect_i;
        if (bmem_read_o) begin
            check_read();
        end
        if (beat_out) begin
            beat_off = beat_off + 32'd8;
            if (beat_off == 32'd32) begin
                mem_busy = 1'b0;
            end
        end
        if (inst_valid_o && inst_ready_i) begin
            check_delivery();
        end
        if (redirect_i) begin
            stale_line = next_line;
            stale_ok   = 1'b1;
            next_line  = {redirect_pc_i[31:5], 5'd0};
            exp_pc     = redirect_pc_i;
        end
    endtask

    task automatic deliver(input int count, input int pct);
        int goal;
        int waited;
        goal      = delivered + count;
        waited    = 0;
        ready_pct = pct;
        while (!aborted && delivered < goal) begin
            step_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: instruction stream stalled after %0d deliveries", delivered);
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic redirect_random(input logic during_fill);
        int waited;
        target_pc     = 32'h40000000 | ($urandom & 32'h0000fffc);
        need_fill     = during_fill;
        want_redirect = 1'b1;
        waited        = 0;
        ready_pct     = 100;
        while (!aborted && want_redirect) begin
            step_cycle();
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: no cycle found to issue a redirect");
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic stall_output(input int cycles);
        ready_pct = 0;
        repeat (cycles) begin
            if (!aborted) begin
                step_cycle();
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        // memory already ready while reset is held
        bmem_ready_i  = 1'b1;
        bmem_raddr_i  = '0;
        bmem_rdata_i  = '0;
        bmem_rvalid_i = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        inst_ready_i  = 1'b0;
        exp_pc        = `FETCH_RESET_PC;
        exp_order     = 64'd0;
        next_line     = `FETCH_RESET_PC;
        stale_line    = 32'd0;
        stale_ok      = 1'b0;
        mem_busy      = 1'b0;
        mem_addr      = 32'd0;
        beat_off      = 32'd0;
        ready_pct     = 0;
        want_redirect = 1'b0;
        need_fill     = 1'b0;
        target_pc     = 32'd0;
        redirect_prev = 1'b0;
        delivered     = 0;
        value_errs    = 0;
        proto_errs    = 0;
        timeouts      = 0;
        aborted       = 1'b0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!bmem_read_o) else begin
            $display("** Error: bmem_read_o = %h after reset, expected 0", bmem_read_o);
            proto_errs++;
        end
        assert (!inst_valid_o) else begin
            $display("** Error: inst_valid_o = %h after reset, expected 0", inst_valid_o);
            proto_errs++;
        end

        deliver(40, 80);
        // back-pressure fills the queue
        stall_output(60);
        deliver(60, 50);
        for (int i = 0; i < 12; i++) begin
            redirect_random(i[0]);
            deliver(5 + int'($urandom % 25), 30 + int'($urandom % 70));
        end
        deliver(30, 70);

        $display("%0d value errors, %0d protocol errors, %0d timeouts, %0d instructions",
                 value_errs, proto_errs, timeouts, delivered);
        if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
